// File: design/axi_bridge_consts.svh
`ifndef AXI_BRIDGE_CONSTS_SVH
`define AXI_BRIDGE_CONSTS_SVH

// ---------------------------------------------------------------------------
// AXI4 channel widths
// ---------------------------------------------------------------------------
`define AXI_ADDR_W 32
`define AXI_DATA_W 64
`define AXI_STRB_W 8
`define AXI_ID_W   4
`define AXI_LEN_W  8
`define AXI_SIZE_W 3

// ---------------------------------------------------------------------------
// fixed transaction IDs, one per master
// ---------------------------------------------------------------------------
`define FETCH_AXI_ID 4'd0
`define DMEM_AXI_ID  4'd1

`endif

// File: design/axi_bridge_pkg.sv
package axi_bridge_pkg;

    // ------------------------------------------------------------------------
    // response codes on the R and B channels
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        // exclusive access succeeded
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        // no slave at this address
        resp_decerr = 2'b11
    } axi_resp_t;

    // ------------------------------------------------------------------------
    // burst types on the AR and AW channels
    // ------------------------------------------------------------------------
    // encoding 2'b11 is reserved by the bus spec
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_t;

endpackage

// File: design/axi_read_arbiter.sv
`include "axi_bridge_consts.svh"

module axi_read_arbiter (
    input  logic                           clk,
    input  logic                           rst,

    // instruction fetch master
    input  logic                           if_arvalid,
    input  logic [`AXI_ADDR_W-1:0]         if_araddr,
    input  logic [`AXI_LEN_W-1:0]          if_arlen,
    input  logic [`AXI_SIZE_W-1:0]         if_arsize,
    input  axi_bridge_pkg::axi_burst_t     if_arburst,
    output logic                           if_arready,
    input  logic                           if_rready,
    output logic                           if_rvalid,
    output logic [`AXI_DATA_W-1:0]         if_rdata,
    output axi_bridge_pkg::axi_resp_t      if_rresp,
    output logic                           if_rlast,

    // data memory master
    input  logic                           mem_arvalid,
    input  logic [`AXI_ADDR_W-1:0]         mem_araddr,
    input  logic [`AXI_LEN_W-1:0]          mem_arlen,
    input  logic [`AXI_SIZE_W-1:0]         mem_arsize,
    input  axi_bridge_pkg::axi_burst_t     mem_arburst,
    output logic                           mem_arready,
    input  logic                           mem_rready,
    output logic                           mem_rvalid,
    output logic [`AXI_DATA_W-1:0]         mem_rdata,
    output axi_bridge_pkg::axi_resp_t      mem_rresp,
    output logic                           mem_rlast,

    // shared slave side
    output logic                           io_arvalid,
    output logic [`AXI_ADDR_W-1:0]         io_araddr,
    output logic [`AXI_ID_W-1:0]           io_arid,
    output logic [`AXI_LEN_W-1:0]          io_arlen,
    output logic [`AXI_SIZE_W-1:0]         io_arsize,
    output axi_bridge_pkg::axi_burst_t     io_arburst,
    input  logic                           io_arready,
    output logic                           io_rready,
    input  logic                           io_rvalid,
    input  logic [`AXI_DATA_W-1:0]         io_rdata,
    input  axi_bridge_pkg::axi_resp_t      io_rresp,
    input  logic [`AXI_ID_W-1:0]           io_rid,
    input  logic                           io_rlast
);

    typedef enum logic [1:0] {
        owner_idle,
        owner_fetch,
        owner_data
    } owner_t;

    owner_t                 owner;
    logic                   idle;
    logic                   sel_fetch;
    logic                   ar_fire;
    logic [`AXI_ID_W-1:0]   owner_id;
    logic                   r_done;

    // ------------------------------------------------------------------------
    // AR channel, open only while no burst is in flight
    // ------------------------------------------------------------------------
    assign idle = (owner == owner_idle);

    // fetch has fixed priority over the data port
    assign sel_fetch = if_arvalid;

    assign io_arvalid = idle && (if_arvalid || mem_arvalid);
    assign io_arid    = sel_fetch ? `FETCH_AXI_ID : `DMEM_AXI_ID;
    assign io_araddr  = sel_fetch ? if_araddr  : mem_araddr;
    assign io_arlen   = sel_fetch ? if_arlen   : mem_arlen;
    assign io_arsize  = sel_fetch ? if_arsize  : mem_arsize;
    assign io_arburst = sel_fetch ? if_arburst : mem_arburst;

    assign if_arready  = idle && io_arready;
    assign mem_arready = idle && !if_arvalid && io_arready;

    assign ar_fire = io_arvalid && io_arready;

    // ------------------------------------------------------------------------
    // owner state
    // ------------------------------------------------------------------------
    assign owner_id = (owner == owner_fetch) ? `FETCH_AXI_ID : `DMEM_AXI_ID;

    // release on the accepted last beat, whatever the response code
    assign r_done = io_rvalid && io_rready && io_rlast && (io_rid == owner_id);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner <= owner_idle;
        end else begin
            case (owner)
                owner_idle: begin
                    if (ar_fire) begin
                        owner <= sel_fetch ? owner_fetch : owner_data;
                    end
                end
                owner_fetch, owner_data: begin
                    if (r_done) begin
                        owner <= owner_idle;
                    end
                end
                default: begin
                    owner <= owner_idle;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // R channel steering
    // ------------------------------------------------------------------------
    always_comb begin
        case (owner)
            owner_fetch: io_rready = if_rready;
            owner_data:  io_rready = mem_rready;
            default:     io_rready = 1'b0;
        endcase
    end

    // payload goes to both, valid only to the owner
    assign if_rvalid = (owner == owner_fetch) && io_rvalid;
    assign if_rdata  = io_rdata;
    assign if_rresp  = io_rresp;
    assign if_rlast  = io_rlast;

    assign mem_rvalid = (owner == owner_data) && io_rvalid;
    assign mem_rdata  = io_rdata;
    assign mem_rresp  = io_rresp;
    assign mem_rlast  = io_rlast;

endmodule

// File: design/axi_write_path.sv
`include "axi_bridge_consts.svh"

module axi_write_path (
    input  logic                           clk,
    input  logic                           rst,

    // data memory master
    input  logic                           mem_awvalid,
    input  logic [`AXI_ADDR_W-1:0]         mem_awaddr,
    input  logic [`AXI_LEN_W-1:0]          mem_awlen,
    input  logic [`AXI_SIZE_W-1:0]         mem_awsize,
    input  axi_bridge_pkg::axi_burst_t     mem_awburst,
    output logic                           mem_awready,
    input  logic                           mem_wvalid,
    input  logic [`AXI_DATA_W-1:0]         mem_wdata,
    input  logic [`AXI_STRB_W-1:0]         mem_wstrb,
    input  logic                           mem_wlast,
    output logic                           mem_wready,
    input  logic                           mem_bready,
    output logic                           mem_bvalid,
    output axi_bridge_pkg::axi_resp_t      mem_bresp,

    // slave side
    output logic                           io_awvalid,
    output logic [`AXI_ID_W-1:0]           io_awid,
    output logic [`AXI_ADDR_W-1:0]         io_awaddr,
    output logic [`AXI_LEN_W-1:0]          io_awlen,
    output logic [`AXI_SIZE_W-1:0]         io_awsize,
    output axi_bridge_pkg::axi_burst_t     io_awburst,
    input  logic                           io_awready,
    output logic                           io_wvalid,
    output logic [`AXI_DATA_W-1:0]         io_wdata,
    output logic [`AXI_STRB_W-1:0]         io_wstrb,
    output logic                           io_wlast,
    input  logic                           io_wready,
    output logic                           io_bready,
    input  logic                           io_bvalid,
    input  axi_bridge_pkg::axi_resp_t      io_bresp,
    input  logic [`AXI_ID_W-1:0]           io_bid
);

    logic busy;
    logic aw_fire;
    logic b_done;

    // ------------------------------------------------------------------------
    // AW channel, blocked while a write is in flight
    // ------------------------------------------------------------------------
    assign io_awvalid  = !busy && mem_awvalid;
    assign mem_awready = !busy && io_awready;
    assign io_awid     = `DMEM_AXI_ID;
    assign io_awaddr   = mem_awaddr;
    assign io_awlen    = mem_awlen;
    assign io_awsize   = mem_awsize;
    assign io_awburst  = mem_awburst;

    assign aw_fire = io_awvalid && io_awready;

    // ------------------------------------------------------------------------
    // W and B channels
    // ------------------------------------------------------------------------
    assign io_wvalid  = mem_wvalid;
    assign io_wdata   = mem_wdata;
    assign io_wstrb   = mem_wstrb;
    assign io_wlast   = mem_wlast;
    assign mem_wready = busy && io_wready;

    assign mem_bvalid = busy && io_bvalid;
    assign mem_bresp  = io_bresp;
    assign io_bready  = busy && mem_bready;

    // an error response still ends the transaction
    assign b_done = io_bvalid && io_bready && (io_bid == `DMEM_AXI_ID);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (!busy && aw_fire) begin
            busy <= 1'b1;
        end else if (busy && b_done) begin
            busy <= 1'b0;
        end
    end

endmodule

// File: design/axi_bridge.sv
`include "axi_bridge_consts.svh"

module axi_bridge (
    input  logic                           clk,
    input  logic                           rst,

    // ------------------------------------------------------------------------
    // fetch read port
    // ------------------------------------------------------------------------
    input  logic                           if_arvalid,
    input  logic [`AXI_ADDR_W-1:0]         if_araddr,
    input  logic [`AXI_LEN_W-1:0]          if_arlen,
    input  logic [`AXI_SIZE_W-1:0]         if_arsize,
    input  axi_bridge_pkg::axi_burst_t     if_arburst,
    output logic                           if_arready,
    input  logic                           if_rready,
    output logic                           if_rvalid,
    output logic [`AXI_DATA_W-1:0]         if_rdata,
    output axi_bridge_pkg::axi_resp_t      if_rresp,
    output logic                           if_rlast,

    // ------------------------------------------------------------------------
    // data memory port
    // ------------------------------------------------------------------------
    input  logic                           mem_arvalid,
    input  logic [`AXI_ADDR_W-1:0]         mem_araddr,
    input  logic [`AXI_LEN_W-1:0]          mem_arlen,
    input  logic [`AXI_SIZE_W-1:0]         mem_arsize,
    input  axi_bridge_pkg::axi_burst_t     mem_arburst,
    output logic                           mem_arready,
    input  logic                           mem_rready,
    output logic                           mem_rvalid,
    output logic [`AXI_DATA_W-1:0]         mem_rdata,
    output axi_bridge_pkg::axi_resp_t      mem_rresp,
    output logic                           mem_rlast,
    input  logic                           mem_awvalid,
    input  logic [`AXI_ADDR_W-1:0]         mem_awaddr,
    input  logic [`AXI_LEN_W-1:0]          mem_awlen,
    input  logic [`AXI_SIZE_W-1:0]         mem_awsize,
    input  axi_bridge_pkg::axi_burst_t     mem_awburst,
    output logic                           mem_awready,
    input  logic                           mem_wvalid,
    input  logic [`AXI_DATA_W-1:0]         mem_wdata,
    input  logic [`AXI_STRB_W-1:0]         mem_wstrb,
    input  logic                           mem_wlast,
    output logic                           mem_wready,
    input  logic                           mem_bready,
    output logic                           mem_bvalid,
    output axi_bridge_pkg::axi_resp_t      mem_bresp,

    // ------------------------------------------------------------------------
    // AXI master port toward the slave
    // ------------------------------------------------------------------------
    output logic                           io_arvalid,
    output logic [`AXI_ADDR_W-1:0]         io_araddr,
    output logic [`AXI_ID_W-1:0]           io_arid,
    output logic [`AXI_LEN_W-1:0]          io_arlen,
    output logic [`AXI_SIZE_W-1:0]         io_arsize,
    output axi_bridge_pkg::axi_burst_t     io_arburst,
    input  logic                           io_arready,
    output logic                           io_rready,
    input  logic                           io_rvalid,
    input  logic [`AXI_DATA_W-1:0]         io_rdata,
    input  axi_bridge_pkg::axi_resp_t      io_rresp,
    input  logic [`AXI_ID_W-1:0]           io_rid,
    input  logic                           io_rlast,
    output logic                           io_awvalid,
    output logic [`AXI_ID_W-1:0]           io_awid,
    output logic [`AXI_ADDR_W-1:0]         io_awaddr,
    output logic [`AXI_LEN_W-1:0]          io_awlen,
    output logic [`AXI_SIZE_W-1:0]         io_awsize,
    output axi_bridge_pkg::axi_burst_t     io_awburst,
    input  logic                           io_awready,
    output logic                           io_wvalid,
    output logic [`AXI_DATA_W-1:0]         io_wdata,
    output logic [`AXI_STRB_W-1:0]         io_wstrb,
    output logic                           io_wlast,
    input  logic                           io_wready,
    output logic                           io_bready,
    input  logic                           io_bvalid,
    input  axi_bridge_pkg::axi_resp_t      io_bresp,
    input  logic [`AXI_ID_W-1:0]           io_bid
);

    // read and write paths are independent, port names match one to one
    axi_read_arbiter u_read_arbiter (.*);

    axi_write_path u_write_path (.*);

endmodule

// File: sim/tb_axi_slave.sv
`include "axi_bridge_consts.svh"

module tb_axi_slave (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        arvalid,
    input  logic [`AXI_ADDR_W-1:0]      araddr,
    input  logic [`AXI_ID_W-1:0]        arid,
    input  logic [`AXI_LEN_W-1:0]       arlen,
    output logic                        arready,
    input  logic                        rready,
    output logic                        rvalid,
    output logic [`AXI_DATA_W-1:0]      rdata,
    output axi_bridge_pkg::axi_resp_t   rresp,
    output logic [`AXI_ID_W-1:0]        rid,
    output logic                        rlast,
    input  logic                        awvalid,
    input  logic [`AXI_ID_W-1:0]        awid,
    input  logic [`AXI_ADDR_W-1:0]      awaddr,
    input  logic [`AXI_LEN_W-1:0]       awlen,
    output logic                        awready,
    input  logic                        wvalid,
    input  logic [`AXI_DATA_W-1:0]      wdata,
    input  logic [`AXI_STRB_W-1:0]      wstrb,
    output logic                        wready,
    input  logic                        bready,
    output logic                        bvalid,
    output axi_bridge_pkg::axi_resp_t   bresp,
    output logic [`AXI_ID_W-1:0]        bid
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 KB window, bit 12 of the address only selects the error region
    logic [`AXI_DATA_W-1:0] mem [0:511];
    integer seed = 32'h3c24_9be8;

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic int rand_delay();
        logic [31:0] r;
        r = $random(seed);
        return int'(r[1:0]);
    endfunction

    // ------------------------------------------------------------------------
    // read side, one burst at a time
    // ------------------------------------------------------------------------
    initial begin
        logic [`AXI_ADDR_W-1:0] base;
        logic [`AXI_ADDR_W-1:0] a;
        logic [`AXI_ID_W-1:0]   id;
        int                     len;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = axi_bridge_pkg::resp_okay;
        rid = '0;
        rlast = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst && arvalid && arready) begin
                base = araddr;
                id = arid;
                len = int'(arlen);
                #10 arready = 1'b0;
                for (int i = 0; i <= len; i++) begin
                    repeat (rand_delay()) begin
                        @(posedge clk);
                        #10;
                    end
                    a = base + 32'(i * 8);
                    rvalid = 1'b1;
                    rdata = mem[a[11:3]];
                    rresp = a[12] ? axi_bridge_pkg::resp_slverr : axi_bridge_pkg::resp_okay;
                    rid = id;
                    rlast = (i == len);
                    do @(posedge clk); while (!rready);
                    #10 rvalid = 1'b0;
                    rlast = 1'b0;
                end
            end else begin
                #10 arready = !rst && rand_bit();
            end
        end
    end

    // ------------------------------------------------------------------------
    // write side, strobed byte stores then one response
    // ------------------------------------------------------------------------
    initial begin
        logic [`AXI_ADDR_W-1:0] base;
        logic [`AXI_ADDR_W-1:0] a;
        logic [`AXI_ID_W-1:0]   id;
        int                     len;
        logic                   accepted;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = axi_bridge_pkg::resp_okay;
        bid = '0;
        forever begin
            @(posedge clk);
            if (!rst && awvalid && awready) begin
                base = awaddr;
                id = awid;
                len = int'(awlen);
                #10 awready = 1'b0;
                for (int i = 0; i <= len; i++) begin
                    a = base + 32'(i * 8);
                    accepted = 1'b0;
                    while (!accepted) begin
                        wready = rand_bit();
                        @(posedge clk);
                        accepted = wvalid && wready;
                        if (accepted) begin
                            for (int b = 0; b < `AXI_STRB_W; b++) begin
                                if (wstrb[b]) begin
                                    mem[a[11:3]][8*b +: 8] = wdata[8*b +: 8];
                                end
                            end
                        end
                        #10;
                    end
                end
                wready = 1'b0;
                bvalid = 1'b1;
                bid = id;
                bresp = axi_bridge_pkg::resp_okay;
                do @(posedge clk); while (!bready);
                #10 bvalid = 1'b0;
            end else begin
                #10 awready = !rst && rand_bit();
            end
        end
    end

endmodule

// File: sim/tb_axi_bridge.sv
`include "axi_bridge_consts.svh"

module tb_axi_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_tests = 200;
    localparam int cycle_limit = num_tests * 8 * 20 + 1000;

    logic clk = 1'b0;
    logic rst;
    logic if_arvalid, if_arready, if_rready, if_rvalid, if_rlast;
    logic [`AXI_ADDR_W-1:0] if_araddr;
    logic [`AXI_LEN_W-1:0] if_arlen;
    logic [`AXI_SIZE_W-1:0] if_arsize;
    axi_bridge_pkg::axi_burst_t if_arburst;
    logic [`AXI_DATA_W-1:0] if_rdata;
    axi_bridge_pkg::axi_resp_t if_rresp;
    logic mem_arvalid, mem_arready, mem_rready, mem_rvalid, mem_rlast;
    logic [`AXI_ADDR_W-1:0] mem_araddr;
    logic [`AXI_LEN_W-1:0] mem_arlen;
    logic [`AXI_SIZE_W-1:0] mem_arsize;
    axi_bridge_pkg::axi_burst_t mem_arburst;
    logic [`AXI_DATA_W-1:0] mem_rdata;
    axi_bridge_pkg::axi_resp_t mem_rresp;
    logic mem_awvalid, mem_awready, mem_wvalid, mem_wlast, mem_wready;
    logic mem_bready, mem_bvalid;
    logic [`AXI_ADDR_W-1:0] mem_awaddr;
    logic [`AXI_LEN_W-1:0] mem_awlen;
    logic [`AXI_SIZE_W-1:0] mem_awsize;
    axi_bridge_pkg::axi_burst_t mem_awburst;
    logic [`AXI_DATA_W-1:0] mem_wdata;
    logic [`AXI_STRB_W-1:0] mem_wstrb;
    axi_bridge_pkg::axi_resp_t mem_bresp;
    logic io_arvalid, io_arready, io_rready, io_rvalid, io_rlast;
    logic [`AXI_ADDR_W-1:0] io_araddr;
    logic [`AXI_ID_W-1:0] io_arid, io_rid;
    logic [`AXI_LEN_W-1:0] io_arlen;
    logic [`AXI_SIZE_W-1:0] io_arsize;
    axi_bridge_pkg::axi_burst_t io_arburst;
    logic [`AXI_DATA_W-1:0] io_rdata;
    axi_bridge_pkg::axi_resp_t io_rresp;
    logic io_awvalid, io_awready, io_wvalid, io_wlast, io_wready, io_bready, io_bvalid;
    logic [`AXI_ID_W-1:0] io_awid, io_bid;
    logic [`AXI_ADDR_W-1:0] io_awaddr;
    logic [`AXI_LEN_W-1:0] io_awlen;
    logic [`AXI_SIZE_W-1:0] io_awsize;
    axi_bridge_pkg::axi_burst_t io_awburst;
    logic [`AXI_DATA_W-1:0] io_wdata;
    logic [`AXI_STRB_W-1:0] io_wstrb;
    axi_bridge_pkg::axi_resp_t io_bresp;

    integer seed = 32'h3c24_9be8;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic [`AXI_DATA_W-1:0] model [0:511];
    logic [`AXI_ID_W-1:0] ar_ids [$];
    time ar_times [$];

    always #50 clk = !clk;

    axi_bridge u_axi_bridge (.*);

    tb_axi_slave u_slave (
        .clk(clk), .rst(rst),
        .arvalid(io_arvalid), .araddr(io_araddr), .arid(io_arid), .arlen(io_arlen),
        .arready(io_arready), .rready(io_rready), .rvalid(io_rvalid), .rdata(io_rdata),
        .rresp(io_rresp), .rid(io_rid), .rlast(io_rlast),
        .awvalid(io_awvalid), .awid(io_awid), .awaddr(io_awaddr), .awlen(io_awlen),
        .awready(io_awready), .wvalid(io_wvalid), .wdata(io_wdata), .wstrb(io_wstrb),
        .wready(io_wready), .bready(io_bready), .bvalid(io_bvalid), .bresp(io_bresp),
        .bid(io_bid)
    );

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    // word-aligned address below 8 KB so that bit 12 can select the error region
    function automatic logic [`AXI_ADDR_W-1:0] rand_addr();
        logic [31:0] r;
        r = $random(seed);
        return {19'd0, r[12:3], 3'd0};
    endfunction

    function automatic int rand_len();
        logic [31:0] r;
        r = $random(seed);
        return int'(r[2:0]) + 1;
    endfunction

    // ------------------------------------------------------------------------
    // monitor and timeout
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        cycles++;
        if (io_arvalid && io_arready) begin
            ar_ids.push_back(io_arid);
            ar_times.push_back($time);
            check_value(64'(io_arsize), 64'd3, "io_arsize on accepted read");
            check_value(64'(io_arburst), 64'(axi_bridge_pkg::burst_incr),
                        "io_arburst on accepted read");
        end
        if (io_awvalid && io_awready) begin
            check_value(64'(io_awid), 64'(`DMEM_AXI_ID), "io_awid on accepted write");
            check_value(64'(io_awsize), 64'd3, "io_awsize on accepted write");
            check_value(64'(io_awburst), 64'(axi_bridge_pkg::burst_incr),
                        "io_awburst on accepted write");
        end
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    // issue one read on a master port and collect its beats against the model
    task automatic read_burst(input logic fetch, input logic [`AXI_ADDR_W-1:0] addr,
                              input int len, output time last_t);
        logic [`AXI_ADDR_W-1:0] a;
        logic [`AXI_DATA_W-1:0] exp_data;
        int beats;
        logic done;
        beats = 0;
        done = 1'b0;
        if (fetch) begin
            if_arvalid = 1'b1;
            if_araddr = addr;
            if_arlen = 8'(len - 1);
        end else begin
            mem_arvalid = 1'b1;
            mem_araddr = addr;
            mem_arlen = 8'(len - 1);
        end
        do @(posedge clk); while (!(fetch ? if_arready : mem_arready));
        #10;
        if (fetch) if_arvalid = 1'b0;
        else mem_arvalid = 1'b0;
        while (!done) begin
            if (fetch) if_rready = rand_bit();
            else mem_rready = rand_bit();
            @(posedge clk);
            check_value(64'(fetch ? mem_rvalid : if_rvalid), 64'd0, "rvalid on non-owner");
            if (fetch ? (if_rvalid && if_rready) : (mem_rvalid && mem_rready)) begin
                a = addr + 32'(beats * 8);
                exp_data = model[a[11:3]];
                check_value(fetch ? if_rdata : mem_rdata, exp_data, "read data");
                check_value(64'(fetch ? if_rresp : mem_rresp), a[12] ? 64'd2 : 64'd0,
                            "read response");
                check_value(64'(fetch ? if_rlast : mem_rlast), 64'(beats == len - 1),
                            "rlast position");
                done = fetch ? if_rlast : mem_rlast;
                beats++;
                last_t = $time;
            end
            #10;
        end
        if_rready = fetch ? 1'b0 : if_rready;
        mem_rready = fetch ? mem_rready : 1'b0;
        check_value(64'(beats), 64'(len), "beat count");
    endtask

    task automatic write_burst(input logic [`AXI_ADDR_W-1:0] addr, input int len);
        logic [`AXI_ADDR_W-1:0] a;
        logic accepted;
        mem_awvalid = 1'b1;
        mem_awaddr = addr;
        mem_awlen = 8'(len - 1);
        do @(posedge clk); while (!mem_awready);
        #10 mem_awvalid = 1'b0;
        for (int n = 0; n < len; n++) begin
            mem_wvalid = 1'b1;
            mem_wdata = {$random(seed), $random(seed)};
            mem_wstrb = 8'($random(seed));
            mem_wlast = (n == len - 1);
            do @(posedge clk); while (!mem_wready);
            check_value(64'(io_wlast), 64'(n == len - 1), "io_wlast on write beat");
            a = addr + 32'(n * 8);
            for (int b = 0; b < `AXI_STRB_W; b++) begin
                if (mem_wstrb[b]) model[a[11:3]][8*b +: 8] = mem_wdata[8*b +: 8];
            end
            #10;
        end
        mem_wvalid = 1'b0;
        mem_wlast = 1'b0;
        accepted = 1'b0;
        while (!accepted) begin
            mem_bready = rand_bit();
            @(posedge clk);
            if (mem_bvalid && mem_bready) begin
                accepted = 1'b1;
                check_value(64'(mem_bresp), 64'd0, "write response");
            end
            #10;
        end
        mem_bready = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [`AXI_ADDR_W-1:0] addr_a;
        logic [`AXI_ADDR_W-1:0] addr_b;
        int len_a;
        int len_b;
        int kind;
        time t_a;
        time t_b;
        rst = 1'b1;
        if_arvalid = 1'b0;
        if_araddr = '0;
        if_arlen = '0;
        if_arsize = 3'd3;
        if_arburst = axi_bridge_pkg::burst_incr;
        if_rready = 1'b0;
        mem_arvalid = 1'b0;
        mem_araddr = '0;
        mem_arlen = '0;
        mem_arsize = 3'd3;
        mem_arburst = axi_bridge_pkg::burst_incr;
        mem_rready = 1'b0;
        mem_awvalid = 1'b0;
        mem_awaddr = '0;
        mem_awlen = '0;
        mem_awsize = 3'd3;
        mem_awburst = axi_bridge_pkg::burst_incr;
        mem_wvalid = 1'b0;
        mem_wdata = '0;
        mem_wstrb = '0;
        mem_wlast = 1'b0;
        mem_bready = 1'b0;
        for (int i = 0; i < 512; i++) begin
            model[i] = {32'hc0de_0000 ^ (32'(i) << 3), 32'(i) * 32'h0101_0101};
            u_slave.mem[i] = model[i];
        end
        repeat (16) @(posedge clk);
        #10 rst = 1'b0;
        check_value(64'(io_arvalid), 64'd0, "io_arvalid after reset");
        check_value(64'(io_awvalid), 64'd0, "io_awvalid after reset");
        check_value(64'(if_rvalid), 64'd0, "if_rvalid after reset");
        check_value(64'(mem_rvalid), 64'd0, "mem_rvalid after reset");
        check_value(64'(mem_wready), 64'd0, "mem_wready after reset");
        check_value(64'(mem_bvalid), 64'd0, "mem_bvalid after reset");
        check_value(64'(io_rready), 64'd0, "io_rready after reset");
        for (int t = 0; t < num_tests; t++) begin
            kind = int'($unsigned($random(seed)) % 4);
            addr_a = rand_addr();
            addr_b = rand_addr();
            len_a = rand_len();
            len_b = rand_len();
            ar_ids.delete();
            ar_times.delete();
            case (kind)
                0: read_burst(1'b1, addr_a, len_a, t_a);
                1: read_burst(1'b0, addr_a, len_a, t_a);
                2: begin
                    fork
                        read_burst(1'b1, addr_a, len_a, t_a);
                        read_burst(1'b0, addr_b, len_b, t_b);
                    join
                    check_value(64'(ar_ids.size()), 64'd2, "accepted read count");
                    if (ar_ids.size() == 2) begin
                        check_value(64'(ar_ids[0]), 64'(`FETCH_AXI_ID), "first arid");
                        check_value(64'(ar_times[1] > t_a), 64'd1,
                                    "data read accepted after fetch last beat");
                    end
                    check_value(64'(t_b > t_a), 64'd1,
                                "data burst completes after fetch burst");
                end
                default: begin
                    write_burst(addr_a, len_a);
                    read_burst(1'b0, addr_a, len_a, t_a);
                end
            endcase
            $display("test %0d kind %0d done, errors so far %0d", t, kind, errors);
        end
        $display("tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: axi_bridge.f
+incdir+design
design/axi_bridge_pkg.sv
design/axi_read_arbiter.sv
design/axi_write_path.sv
design/axi_bridge.sv
sim/tb_axi_slave.sv
sim/tb_axi_bridge.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := tb_axi_bridge
FILELIST  := axi_bridge.f
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
